/* Makefile */
SIM ?= verilator
FLAGS = --binary --assert --timing -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
TOP = armCore_tb
FILELIST = list.f
OBJDIR = obj_dir
LOG = sim.log
PASSTEXT = STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "$(PASSTEXT)" $(LOG)

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* bench/armCore_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module armCore_chk (
	input logic clk,
	input logic rst,
	input logic instrValid,
	input logic instrReady,
	input logic [armCorePkg::instrWidth-1:0] instrData,
	input logic retValid,
	input logic retReady,
	input armCorePkg::retireRec retData
);
	// Failure tally, read back by the testbench
	int assertFails = 0;

	// Offered instruction held until taken
	instrHold: assert property (@(posedge clk) disable iff (rst)
		instrValid && !instrReady |=> instrValid && $stable(instrData))
		else begin
			assertFails++;
			$error("instruction word changed or withdrawn while stalled");
		end

	// Retire record held while the sink stalls
	retHold: assert property (@(posedge clk) disable iff (rst)
		retValid && !retReady |=> retValid && $stable(retData))
		else begin
			assertFails++;
			$error("retire record changed or withdrawn while stalled");
		end

	// Empty buffers right after a reset edge
	resetState: assert property (@(posedge clk) rst |=> !retValid && instrReady)
		else begin
			assertFails++;
			$error("stream handshakes not at their reset values after reset");
		end

endmodule

`default_nettype wire

/* bench/armCore_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module armCore_tb;
	import armCorePkg::*;

	localparam int numInstr = 400;
	localparam int cycleBudget = numInstr * 20;

	logic clk, rst;
	logic instrValid, instrReady;
	logic [instrWidth-1:0] instrData;
	logic retValid, retReady;
	retireRec retData;

	// Random source, stall phase, progress counters
	logic [31:0] rngState;
	logic stallMode;
	int issued, accepted, received;
	int mismatches, otherErrors, assertErrors;

	// Reference machine state
	logic [dataWidth-1:0] modelRegs [32];
	logic [7:0] modelMem [memWords * 8];
	logic [flagWidth-1:0] modelFlags;
	logic [dataWidth-1:0] modelPc;
	retireRec expQ [$];

	clockGen #(.period(4), .resetCycles(4)) clocks (.clk(clk), .rst(rst));

	armCore dut (
		.clk(clk), .rst(rst),
		.instrValid(instrValid), .instrReady(instrReady), .instrData(instrData),
		.retValid(retValid), .retReady(retReady), .retData(retData)
	);

	// Handshake assertions inside the core
	bind armCore armCore_chk handshakeChk (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] nextRand();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	// Mostly X0 to X3, sometimes X31
	function automatic logic [4:0] pickReg(input logic [2:0] sel);
		return (sel == 3'd7) ? 5'd31 : {3'b000, sel[1:0]};
	endfunction

	function automatic logic [dataWidth-1:0] readReg(input logic [4:0] idx);
		return (idx == 5'd31) ? '0 : modelRegs[idx];
	endfunction

	// One random word from the subset, now and then an illegal one
	function automatic logic [instrWidth-1:0] makeInstr();
		logic [31:0] r1, r2;
		logic [4:0] rd, rn, rm, memBase;
		logic [8:0] imm9;
		logic [instrWidth-1:0] w;
		r1 = nextRand();
		r2 = nextRand();
		rd = pickReg(r1[6:4]);
		rn = pickReg(r1[9:7]);
		rm = pickReg(r1[12:10]);
		// X31 base keeps addresses near both ends of memory
		memBase = r1[13] ? 5'd31 : rn;
		imm9 = {{3{r2[20]}}, r2[17:12]};
		case (r1[3:0])
			4'd0: w = {opAdd, rm, 6'd0, rn, rd};
			4'd1: w = {opSub, rm, 6'd0, rn, rd};
			4'd2: w = {opAdds, rm, 6'd0, rn, rd};
			4'd3: w = {opSubs, rm, 6'd0, rn, rd};
			4'd4: w = {opAnd, rm, 6'd0, rn, rd};
			4'd5: w = {opOrr, rm, 6'd0, rn, rd};
			4'd6: w = {opEor, rm, 6'd0, rn, rd};
			4'd7, 4'd8, 4'd15: w = {opAddi, r2[11:0], rn, rd};
			4'd9: w = {opSubi, r2[11:0], rn, rd};
			4'd10: w = {opLdur, imm9, 2'b00, memBase, rd};
			4'd11: w = {opStur, imm9, 2'b00, memBase, rd};
			4'd12: w = {opLdurb, imm9, 2'b00, memBase, rd};
			4'd13: w = {opSturb, imm9, 2'b00, memBase, rd};
			// Top nibble 0000 matches no opcode
			default: w = {4'b0000, r2[27:0]};
		endcase
		return w;
	endfunction

	// Runs one accepted word and queues its expected record
	task automatic modelStep(input logic [instrWidth-1:0] w);
		logic [10:0] op11;
		logic [9:0] op10;
		logic [dataWidth-1:0] a, b, res, stData;
		logic [dataWidth:0] wide;
		logic [memAddrWidth-1:0] addr, base;
		logic doWrite, doFlags, arith, isSub, v, c;
		retireRec r;
		int i;
		op11 = w[31:21];
		op10 = w[31:22];
		a = readReg(w[9:5]);
		b = readReg(w[20:16]);
		stData = readReg(w[4:0]);
		res = '0;
		doWrite = 1'b1;
		doFlags = 1'b0;
		arith = 1'b0;
		isSub = 1'b0;
		v = 1'b0;
		c = 1'b0;
		r = '0;
		r.pc = modelPc;
		r.dest = w[4:0];
		// Base plus signed offset, upper bits dropped
		addr = memAddrWidth'(a + {{(dataWidth - 9){w[20]}}, w[20:12]});
		base = {addr[memAddrWidth-1:3], 3'b000};
		if (op11 == opAdd || op11 == opAdds || op11 == opSub || op11 == opSubs) begin
			arith = 1'b1;
			isSub = (op11 == opSub) || (op11 == opSubs);
			doFlags = (op11 == opAdds) || (op11 == opSubs);
		end else if (op11 == opAnd) begin
			res = a & b;
		end else if (op11 == opOrr) begin
			res = a | b;
		end else if (op11 == opEor) begin
			res = a ^ b;
		end else if (op11 == opLdur) begin
			// Little-endian from the aligned doubleword
			for (i = 0; i < 8; i++)
				res[8*i +: 8] = modelMem[base + memAddrWidth'(i)];
		end else if (op11 == opLdurb) begin
			res = {{(dataWidth - 8){1'b0}}, modelMem[addr]};
		end else if (op11 == opStur) begin
			doWrite = 1'b0;
			r.isStore = 1'b1;
			r.storeAddr = addr;
			for (i = 0; i < 8; i++)
				modelMem[base + memAddrWidth'(i)] = stData[8*i +: 8];
		end else if (op11 == opSturb) begin
			doWrite = 1'b0;
			r.isStore = 1'b1;
			r.storeAddr = addr;
			modelMem[addr] = stData[7:0];
		end else if (op10 == opAddi || op10 == opSubi) begin
			// Zero-extended imm12
			b = {{(dataWidth - 12){1'b0}}, w[21:10]};
			arith = 1'b1;
			isSub = (op10 == opSubi);
		end else begin
			doWrite = 1'b0;
			r.illegal = 1'b1;
		end
		if (arith && isSub) begin
			res = a - b;
			// C set when no borrow
			c = (a >= b);
			v = (a[dataWidth-1] != b[dataWidth-1]) && (res[dataWidth-1] != a[dataWidth-1]);
		end else if (arith) begin
			wide = {1'b0, a} + {1'b0, b};
			res = wide[dataWidth-1:0];
			c = wide[dataWidth];
			v = (a[dataWidth-1] == b[dataWidth-1]) && (res[dataWidth-1] != a[dataWidth-1]);
		end
		if (doFlags)
			modelFlags = {res[dataWidth-1], res == '0, v, c};
		// X31 writes vanish
		if (doWrite && w[4:0] != 5'd31) begin
			modelRegs[w[4:0]] = res;
			r.writeEnable = 1'b1;
			r.writeData = res;
		end
		r.flags = modelFlags;
		modelPc = modelPc + dataWidth'(4);
		expQ.push_back(r);
	endtask

	task automatic checkValue(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			mismatches++;
			$display("MISMATCH %s in record %0d: expected 0x%h, actual 0x%h",
				name, received, expected, actual);
		end
	endtask

	task automatic compareRecord(input retireRec e, input retireRec a);
		checkValue("pc", e.pc, a.pc);
		checkValue("dest", 64'(e.dest), 64'(a.dest));
		checkValue("writeEnable", 64'(e.writeEnable), 64'(a.writeEnable));
		checkValue("writeData", e.writeData, a.writeData);
		checkValue("isStore", 64'(e.isStore), 64'(a.isStore));
		checkValue("storeAddr", 64'(e.storeAddr), 64'(a.storeAddr));
		checkValue("flags", 64'(e.flags), 64'(a.flags));
		checkValue("illegal", 64'(e.illegal), 64'(a.illegal));
	endtask

	// Falling-edge stimulus
	task automatic driveInputs();
		logic [31:0] r;
		r = nextRand();
		// Stall phases of a few dozen cycles fill both buffers
		if (r[12:8] == 5'd0)
			stallMode = !stallMode;
		retReady = stallMode ? (r[3:0] == 4'd0) : (r[1:0] != 2'd0);
		// Offered word stays until taken
		if (!instrValid || accepted == issued) begin
			if (issued < numInstr && r[5:4] != 2'd0) begin
				instrData = makeInstr();
				instrValid = 1'b1;
				issued++;
			end else begin
				instrValid = 1'b0;
			end
		end
	endtask

	// Transfers seen on the rising edge
	always @(posedge clk) begin
		if (!rst) begin
			if (instrValid && instrReady) begin
				modelStep(instrData);
				accepted++;
			end
			if (retValid && retReady) begin
				if (expQ.size() == 0) begin
					otherErrors++;
					$display("Retire record with pc 0x%h arrived with no instruction outstanding",
						retData.pc);
				end else begin
					compareRecord(expQ.pop_front(), retData);
				end
				received++;
			end
		end
	end

	initial begin
		int i;
		instrValid = 1'b0;
		instrData = '0;
		retReady = 1'b0;
		rngState = 32'ha6d3;
		stallMode = 1'b0;
		issued = 0;
		accepted = 0;
		received = 0;
		mismatches = 0;
		otherErrors = 0;
		assertErrors = 0;
		modelFlags = '0;
		modelPc = '0;
		for (i = 0; i < 32; i++)
			modelRegs[i] = '0;
		for (i = 0; i < memWords * 8; i++)
			modelMem[i] = '0;
		wait (rst === 1'b0);
		@(negedge clk);
		while (received < numInstr) begin
			driveInputs();
			@(negedge clk);
		end
		// Output left open to catch stray records
		instrValid = 1'b0;
		retReady = 1'b1;
		repeat (20) @(negedge clk);
		assertErrors = dut.handshakeChk.assertFails;
		if (received != numInstr || expQ.size() != 0) begin
			otherErrors++;
			$display("Received %0d retire records for %0d instructions sent",
				received, numInstr);
		end
		$display("Errors: %0d mismatches, %0d other, %0d assertion failures over %0d records",
			mismatches, otherErrors, assertErrors, received);
		if (mismatches + otherErrors + assertErrors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// Watchdog sized from the instruction count
	initial begin
		repeat (cycleBudget) @(posedge clk);
		$display("Timed out after %0d cycles with %0d of %0d records received",
			cycleBudget, received, numInstr);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/clockGen.sv */
`timescale 1ns/1ns
`default_nettype none

module clockGen #(
	parameter int period = 4,
	parameter int resetCycles = 4
) (
	output logic clk,
	output logic rst
);
	// Free-running clock
	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// Reset spans the first rising edges, drops on a falling edge
	initial begin
		rst = 1'b1;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

/* list.f */
logic/armCorePkg.sv
logic/streamFifo.sv
logic/controlDecode.sv
logic/regFile.sv
logic/alu.sv
logic/dataMem.sv
logic/datapath.sv
logic/armCore.sv
bench/clockGen.sv
bench/armCore_chk.sv
bench/armCore_tb.sv

/* logic/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
	input logic [armCorePkg::dataWidth-1:0] a,
	input logic [armCorePkg::dataWidth-1:0] b,
	input armCorePkg::aluOp op,
	output logic [armCorePkg::dataWidth-1:0] result,
	output logic negative,
	output logic zero,
	output logic overflow,
	output logic carryOut
);
	import armCorePkg::*;

	logic isSub;
	logic isArith;
	logic [dataWidth-1:0] bSel;
	logic [dataWidth:0] sum;

	assign isSub = (op == aluSub);
	assign isArith = (op == aluAdd) || isSub;

	// Subtract as a + ~b + 1
	assign bSel = isSub ? ~b : b;
	assign sum = {1'b0, a} + {1'b0, bSel} + {{dataWidth{1'b0}}, isSub};

	always_comb begin
		case (op)
			aluAdd, aluSub: result = sum[dataWidth-1:0];
			aluAnd: result = a & b;
			aluOrr: result = a | b;
			aluEor: result = a ^ b;
			default: result = b;
		endcase
	end

	// N and Z from the result for every op
	assign negative = result[dataWidth-1];
	assign zero = (result == '0);
	// C is carry out, so no borrow on subtract
	assign carryOut = isArith && sum[dataWidth];
	// Same-sign operands giving a result of the other sign
	assign overflow = isArith && (a[dataWidth-1] == bSel[dataWidth-1])
		&& (sum[dataWidth-1] != a[dataWidth-1]);

endmodule

`default_nettype wire

/* logic/armCore.sv */
`timescale 1ns/1ns
`default_nettype none

module armCore (
	input logic clk,
	input logic rst,
	input logic instrValid,
	output logic instrReady,
	input logic [armCorePkg::instrWidth-1:0] instrData,
	output logic retValid,
	input logic retReady,
	output armCorePkg::retireRec retData
);
	import armCorePkg::*;

	logic headValid, retInReady, execute;
	logic [instrWidth-1:0] headInstr;
	aluOp aluOpSel;
	xferSize xfer;
	logic useImm12, useImm9, regWrite, memWrite, memRead, setFlags, illegal;
	logic [regAddrWidth-1:0] rn, rm, rd;
	logic [flagWidth-1:0] flags;
	logic [dataWidth-1:0] wbData, pcReg;
	logic [memAddrWidth-1:0] storeAddr;
	logic recWrite;
	retireRec rec;

	// Instruction buffer
	streamFifo #(.payloadType(logic [instrWidth-1:0]), .depth(fifoDepth)) instrFifo (
		.clk(clk), .rst(rst),
		.inValid(instrValid), .inReady(instrReady), .inData(instrData),
		.outValid(headValid), .outReady(execute), .outData(headInstr)
	);

	// Head executes only when the retire side has room
	assign execute = headValid && retInReady;

	controlDecode decode (
		.instr(headInstr), .aluOpSel(aluOpSel),
		.useImm12(useImm12), .useImm9(useImm9), .regWrite(regWrite),
		.memWrite(memWrite), .memRead(memRead), .setFlags(setFlags),
		.illegal(illegal), .xfer(xfer), .rn(rn), .rm(rm), .rd(rd)
	);

	datapath dp (
		.clk(clk), .rst(rst), .commit(execute),
		.aluOpSel(aluOpSel), .useImm12(useImm12), .useImm9(useImm9),
		.regWrite(regWrite), .memWrite(memWrite), .memRead(memRead),
		.setFlags(setFlags), .xfer(xfer), .rn(rn), .rm(rm), .rd(rd),
		.instr(headInstr), .flags(flags), .writeData(wbData), .storeAddr(storeAddr)
	);

	// PC counts retired instructions
	always_ff @(posedge clk) begin
		if (rst)
			pcReg <= '0;
		else if (execute)
			pcReg <= pcReg + dataWidth'(4);
	end

	// Unused record fields read as zero
	assign recWrite = regWrite && (rd != '1);
	always_comb begin
		rec.pc = pcReg;
		rec.dest = rd;
		rec.writeEnable = recWrite;
		rec.writeData = recWrite ? wbData : '0;
		rec.isStore = memWrite;
		rec.storeAddr = memWrite ? storeAddr : '0;
		rec.flags = flags;
		rec.illegal = illegal;
	end

	// Retire buffer
	streamFifo #(.payloadType(retireRec), .depth(fifoDepth)) retFifo (
		.clk(clk), .rst(rst),
		.inValid(execute), .inReady(retInReady), .inData(rec),
		.outValid(retValid), .outReady(retReady), .outData(retData)
	);

endmodule

`default_nettype wire

/* logic/armCorePkg.sv */
`default_nettype none

package armCorePkg;

	// Datapath and instruction widths
	localparam int dataWidth = 64;
	localparam int instrWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int flagWidth = 4;

	// 64 doublewords of data memory, byte addressed
	localparam int memWords = 64;
	localparam int memAddrWidth = $clog2(memWords * 8);

	// Depth of both stream buffers
	localparam int fifoDepth = 4;

	// Register forms, 11-bit opcodes in instr[31:21]
	localparam logic [10:0] opAdd = 11'b10001011000;
	localparam logic [10:0] opSub = 11'b11001011000;
	localparam logic [10:0] opAdds = 11'b10101011000;
	localparam logic [10:0] opSubs = 11'b11101011000;
	localparam logic [10:0] opAnd = 11'b10001010000;
	localparam logic [10:0] opOrr = 11'b10101010000;
	localparam logic [10:0] opEor = 11'b11001010000;

	// Memory forms, 11-bit opcodes in instr[31:21]
	localparam logic [10:0] opLdur = 11'b11111000010;
	localparam logic [10:0] opStur = 11'b11111000000;
	localparam logic [10:0] opLdurb = 11'b00111000010;
	localparam logic [10:0] opSturb = 11'b00111000000;

	// Immediate forms, 10-bit opcodes in instr[31:22]
	localparam logic [9:0] opAddi = 10'b1001000100;
	localparam logic [9:0] opSubi = 10'b1101000100;

	typedef enum logic [2:0] {
		aluPassB = 3'd0,
		aluAdd = 3'd1,
		aluSub = 3'd2,
		aluAnd = 3'd3,
		aluOrr = 3'd4,
		aluEor = 3'd5
	} aluOp;

	typedef enum logic {
		xferByte = 1'b0,
		xferDouble = 1'b1
	} xferSize;

	// One record per executed instruction, flags packed as {N, Z, V, C}
	typedef struct packed {
		logic [dataWidth-1:0] pc;
		logic [regAddrWidth-1:0] dest;
		logic writeEnable;
		logic [dataWidth-1:0] writeData;
		logic isStore;
		logic [memAddrWidth-1:0] storeAddr;
		logic [flagWidth-1:0] flags;
		logic illegal;
	} retireRec;

endpackage

`default_nettype wire

/* logic/controlDecode.sv */
`timescale 1ns/1ns
`default_nettype none

module controlDecode (
	input logic [armCorePkg::instrWidth-1:0] instr,
	output armCorePkg::aluOp aluOpSel,
	output logic useImm12,
	output logic useImm9,
	output logic regWrite,
	output logic memWrite,
	output logic memRead,
	output logic setFlags,
	output logic illegal,
	output armCorePkg::xferSize xfer,
	output logic [armCorePkg::regAddrWidth-1:0] rn,
	output logic [armCorePkg::regAddrWidth-1:0] rm,
	output logic [armCorePkg::regAddrWidth-1:0] rd
);
	import armCorePkg::*;

	logic [10:0] opcode11;
	logic [9:0] opcode10;

	assign opcode11 = instr[31:21];
	assign opcode10 = instr[31:22];

	// Fixed register fields
	assign rn = instr[9:5];
	assign rd = instr[4:0];
	// Second read port takes Rt for stores, like Reg2Loc
	assign rm = memWrite ? instr[4:0] : instr[20:16];

	always_comb begin
		// Defaults give a no-op with no writes
		aluOpSel = aluPassB;
		useImm12 = 1'b0;
		useImm9 = 1'b0;
		regWrite = 1'b0;
		memWrite = 1'b0;
		memRead = 1'b0;
		setFlags = 1'b0;
		illegal = 1'b0;
		xfer = xferDouble;
		// Register and memory forms first, then the immediate forms
		if (opcode11 == opAdd || opcode11 == opAdds) begin
			aluOpSel = aluAdd;
			regWrite = 1'b1;
			setFlags = (opcode11 == opAdds);
		end else if (opcode11 == opSub || opcode11 == opSubs) begin
			aluOpSel = aluSub;
			regWrite = 1'b1;
			setFlags = (opcode11 == opSubs);
		end else if (opcode11 == opAnd) begin
			aluOpSel = aluAnd;
			regWrite = 1'b1;
		end else if (opcode11 == opOrr) begin
			aluOpSel = aluOrr;
			regWrite = 1'b1;
		end else if (opcode11 == opEor) begin
			aluOpSel = aluEor;
			regWrite = 1'b1;
		end else if (opcode11 == opLdur || opcode11 == opLdurb) begin
			// Address is Rn plus imm9
			aluOpSel = aluAdd;
			useImm9 = 1'b1;
			regWrite = 1'b1;
			memRead = 1'b1;
			xfer = (opcode11 == opLdur) ? xferDouble : xferByte;
		end else if (opcode11 == opStur || opcode11 == opSturb) begin
			aluOpSel = aluAdd;
			useImm9 = 1'b1;
			memWrite = 1'b1;
			xfer = (opcode11 == opStur) ? xferDouble : xferByte;
		end else if (opcode10 == opAddi || opcode10 == opSubi) begin
			aluOpSel = (opcode10 == opAddi) ? aluAdd : aluSub;
			useImm12 = 1'b1;
			regWrite = 1'b1;
		end else begin
			illegal = 1'b1;
		end
	end

endmodule

`default_nettype wire

/* logic/dataMem.sv */
`timescale 1ns/1ns
`default_nettype none

module dataMem (
	input logic clk,
	input logic rst,
	input logic [armCorePkg::memAddrWidth-1:0] addr,
	input logic writeEnable,
	input armCorePkg::xferSize xfer,
	input logic [armCorePkg::dataWidth-1:0] writeData,
	output logic [armCorePkg::dataWidth-1:0] readData
);
	import armCorePkg::*;

	localparam int memBytes = memWords * 8;

	logic [7:0] bytes [memBytes];
	logic [dataWidth-1:0] dwData;

	// Doubleword gathered little-endian from the aligned base
	always_comb begin
		for (int i = 0; i < 8; i++)
			dwData[8*i +: 8] = bytes[{addr[memAddrWidth-1:3], 3'(i)}];
	end

	// Byte reads zero-extended
	assign readData = (xfer == xferDouble) ? dwData : {{(dataWidth - 8){1'b0}}, bytes[addr]};

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < memBytes; i++)
				bytes[i] <= '0;
		end else if (writeEnable) begin
			if (xfer == xferDouble) begin
				// Low three address bits ignored
				for (int i = 0; i < 8; i++)
					bytes[{addr[memAddrWidth-1:3], 3'(i)}] <= writeData[8*i +: 8];
			end else begin
				bytes[addr] <= writeData[7:0];
			end
		end
	end

endmodule

`default_nettype wire

/* logic/datapath.sv */
`timescale 1ns/1ns
`default_nettype none

module datapath (
	input logic clk,
	input logic rst,
	input logic commit,
	input armCorePkg::aluOp aluOpSel,
	input logic useImm12,
	input logic useImm9,
	input logic regWrite,
	input logic memWrite,
	input logic memRead,
	input logic setFlags,
	input armCorePkg::xferSize xfer,
	input logic [armCorePkg::regAddrWidth-1:0] rn,
	input logic [armCorePkg::regAddrWidth-1:0] rm,
	input logic [armCorePkg::regAddrWidth-1:0] rd,
	input logic [armCorePkg::instrWidth-1:0] instr,
	output logic [armCorePkg::flagWidth-1:0] flags,
	output logic [armCorePkg::dataWidth-1:0] writeData,
	output logic [armCorePkg::memAddrWidth-1:0] storeAddr
);
	import armCorePkg::*;

	logic [dataWidth-1:0] regA, regB, imm12Ext, imm9Ext, aluB, aluResult, memData;
	logic negative, zero, overflow, carryOut;
	logic [flagWidth-1:0] flagReg, nextFlags;

	regFile regs (
		.clk(clk), .rst(rst),
		.readAddrA(rn), .readAddrB(rm),
		.readDataA(regA), .readDataB(regB),
		.writeEnable(regWrite && commit), .writeAddr(rd), .writeData(writeData)
	);

	// Imm12 zero-extended, imm9 sign-extended
	assign imm12Ext = {{(dataWidth - 12){1'b0}}, instr[21:10]};
	assign imm9Ext = {{(dataWidth - 9){instr[20]}}, instr[20:12]};

	// Operand B from register, imm12 or imm9
	assign aluB = useImm12 ? imm12Ext : (useImm9 ? imm9Ext : regB);

	alu theAlu (
		.a(regA), .b(aluB), .op(aluOpSel), .result(aluResult),
		.negative(negative), .zero(zero), .overflow(overflow), .carryOut(carryOut)
	);

	// All four flags registered, Z included
	assign nextFlags = {negative, zero, overflow, carryOut};
	always_ff @(posedge clk) begin
		if (rst)
			flagReg <= '0;
		else if (commit && setFlags)
			flagReg <= nextFlags;
	end
	// Flags as seen after this instruction
	assign flags = setFlags ? nextFlags : flagReg;

	// Store data from the Rt read port
	assign storeAddr = aluResult[memAddrWidth-1:0];
	dataMem mem (
		.clk(clk), .rst(rst), .addr(storeAddr),
		.writeEnable(memWrite && commit), .xfer(xfer),
		.writeData(regB), .readData(memData)
	);

	// Loads write back memory data
	assign writeData = memRead ? memData : aluResult;

endmodule

`default_nettype wire

/* logic/regFile.sv */
`timescale 1ns/1ns
`default_nettype none

module regFile (
	input logic clk,
	input logic rst,
	input logic [armCorePkg::regAddrWidth-1:0] readAddrA,
	input logic [armCorePkg::regAddrWidth-1:0] readAddrB,
	output logic [armCorePkg::dataWidth-1:0] readDataA,
	output logic [armCorePkg::dataWidth-1:0] readDataB,
	input logic writeEnable,
	input logic [armCorePkg::regAddrWidth-1:0] writeAddr,
	input logic [armCorePkg::dataWidth-1:0] writeData
);
	import armCorePkg::*;

	localparam int regCount = 2 ** regAddrWidth;
	localparam logic [regAddrWidth-1:0] zeroReg = regAddrWidth'(regCount - 1);

	logic [dataWidth-1:0] regs [regCount];

	// X31 reads as zero
	assign readDataA = (readAddrA == zeroReg) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == zeroReg) ? '0 : regs[readAddrB];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < regCount; i++)
				regs[i] <= '0;
		end else if (writeEnable && writeAddr != zeroReg) begin
			// Writes to X31 dropped
			regs[writeAddr] <= writeData;
		end
	end

endmodule

`default_nettype wire

/* logic/streamFifo.sv */
`timescale 1ns/1ns
`default_nettype none

module streamFifo #(
	parameter type payloadType = logic [31:0],
	parameter int depth = 4
) (
	input logic clk,
	input logic rst,
	input logic inValid,
	output logic inReady,
	input payloadType inData,
	output logic outValid,
	input logic outReady,
	output payloadType outData
);
	localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
	localparam int cntWidth = $clog2(depth + 1);

	payloadType store [depth];
	logic [ptrWidth-1:0] rdPtr, wrPtr;
	logic [cntWidth-1:0] count;
	logic push, pop;

	// Empty means no valid; full still takes a word if the head leaves
	assign outValid = (count != '0);
	assign inReady = (count != cntWidth'(depth)) || outReady;
	assign push = inValid && inReady;
	assign pop = outValid && outReady;
	assign outData = store[rdPtr];

	// Payload storage
	always_ff @(posedge clk) begin
		if (push)
			store[wrPtr] <= inData;
	end

	// Pointers wrap at depth, count tracks occupancy
	always_ff @(posedge clk) begin
		if (rst) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end else begin
			if (push)
				wrPtr <= (wrPtr == ptrWidth'(depth - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == ptrWidth'(depth - 1)) ? '0 : rdPtr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire
